// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
LINTFLAGS ?= --lint-only --timing
TOP       := tb_cu_top
FILELIST  := files.f
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== files.f ====
verilog/cu_pkg.sv
verilog/cu_session_ctrl.sv
verilog/cu_point_gate.sv
verilog/cu_cache_sequencer.sv
verilog/alfa_cu_top.sv
test/tb_clock_gen.sv
test/tb_cu_checker.sv
test/tb_cu_top.sv

// ==== test/tb_clock_gen.sv ====
// testbench clock and reset
`timescale 1ns/100ps

module tb_clock_gen
(
    output logic o_clk,
    output logic o_rst
);

    initial
    begin
        o_clk = 1'b0;
        forever #10 o_clk = ~o_clk; // 20 ns period.
    end

    // reset covers 16 rising edges.
    initial
    begin
        o_rst = 1'b1;
        repeat (16) @(posedge o_clk);
        #2;
        o_rst = 1'b0;
    end

endmodule

// ==== test/tb_cu_checker.sv ====
// control unit reference checker
`timescale 1ns/100ps

module tb_cu_checker
(
    input  logic                        i_SYSTEM_clk,
    input  logic                        i_SYSTEM_rst,
    input  cu_pkg::ext_in_t             i_ext,
    input  cu_pkg::exmu_in_t            i_exmu,
    input  cu_pkg::int_stat_t           i_int,
    input  cu_pkg::unit_status_t        i_status,
    input  logic                        i_pc_ready,
    input  cu_pkg::ext_out_t            i_dut_ext,
    input  cu_pkg::exmu_cmd_t           i_dut_cmd,
    input  cu_pkg::exmu_point_t         i_dut_point,
    input  cu_pkg::int_cmd_t            i_dut_int,
    input  logic                        i_dut_ext_ready,
    input  logic                        i_dut_done,
    input  logic [cu_pkg::STATUS_W-1:0] i_dut_status,
    output int                          o_mismatches,
    output logic [3:0]                  o_seen // write_mem, write_cache, read_cache, done.
);

    cu_pkg::cu_state_e  st;
    cu_pkg::cu_state_e  nxt_st;
    cu_pkg::exmu_cmd_t  cmd;
    cu_pkg::int_cmd_t   ic;
    logic               pc_q, en, wr_q, rv_q, rs_q, pd, first;
    logic               fin, exp_wp, exp_rp, fault, swap_ok, rise;
    logic               armed = 1'b0;
    logic [3:0]         seen = 4'b0000;
    int                 mismatches = 0;

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            mismatches++;
            $display("** Error %0d ns: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    task automatic check_word(input string name, input logic [cu_pkg::STATUS_W-1:0] expected,
                              input logic [cu_pkg::STATUS_W-1:0] actual);
        if (actual !== expected)
        begin
            mismatches++;
            $display("** Error %0d ns: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    // inputs are stable here, so outputs are compared and the next edge is predicted.
    always @(negedge i_SYSTEM_clk)
    begin
        fin = (st == cu_pkg::EXT_LAST_WRITE) || (st == cu_pkg::EXT_LAST_WRITE_T_OFF)
            || (st == cu_pkg::EXT_END);
        exp_wp = !fin && i_exmu.write_in_cache && wr_q && i_ext.write_valid;
        exp_rp = !fin && i_exmu.read_in_cache && i_ext.read_ready && !rs_q;
        if (armed)
        begin
            check_bit("enable", en, i_dut_ext.enable);
            check_bit("write_ready", wr_q, i_dut_ext.write_ready);
            check_bit("read_valid", rv_q, i_dut_ext.read_valid);
            check_bit("write_point", exp_wp, i_dut_point.write_point);
            check_bit("read_point", exp_rp, i_dut_point.read_point);
            check_bit("write_mem", cmd.write_mem, i_dut_cmd.write_mem);
            check_bit("write_cache", cmd.write_cache, i_dut_cmd.write_cache);
            check_bit("read_cache", cmd.read_cache, i_dut_cmd.read_cache);
            check_bit("read_write_id", cmd.read_write_id, i_dut_cmd.read_write_id);
            check_bit("init_write_tx", ic.init_write_tx, i_dut_int.init_write_tx);
            check_bit("init_read_tx", ic.init_read_tx, i_dut_int.init_read_tx);
            check_bit("monu_ext_ready", !en, i_dut_ext_ready);
            check_bit("processing_done", pd, i_dut_done);
            check_word("status", {{(cu_pkg::STATUS_W - cu_pkg::STATE_W){1'b0}}, st}, i_dut_status);
            seen = seen | {cmd.write_mem, cmd.write_cache, cmd.read_cache, pd};
        end
        fault = (i_status.memmu == cu_pkg::STATUS_FAULT) || (i_status.exmu == cu_pkg::STATUS_FAULT)
              || (i_status.monu == cu_pkg::STATUS_FAULT);
        swap_ok = i_pc_ready && i_int.read_txn_done && i_int.write_txn_done;
        nxt_st = st;
        case (st)
            cu_pkg::RESET:               nxt_st = cu_pkg::IDLE;
            cu_pkg::IDLE:
            begin
                if (i_ext.done_processing)
                    nxt_st = cu_pkg::EXT_LAST_WRITE;
                else if (swap_ok && !i_exmu.write_in_cache && first)
                    nxt_st = cu_pkg::EXT_WRITE_CACHE; // nothing to write back yet.
                else if (swap_ok && !i_exmu.write_in_cache)
                    nxt_st = cu_pkg::EXT_WRITE_MEM;
                else if (swap_ok && !i_exmu.read_in_cache)
                    nxt_st = cu_pkg::EXT_READ_CACHE;
            end
            cu_pkg::EXT_WRITE_MEM:       nxt_st = cu_pkg::EXT_WRITE_MEM_T_OFF;
            cu_pkg::EXT_WRITE_MEM_T_OFF: nxt_st = cu_pkg::EXT_WRITE_MEM_END;
            cu_pkg::EXT_WRITE_MEM_END:   nxt_st = cu_pkg::EXT_WRITE_CACHE;
            cu_pkg::EXT_WRITE_CACHE:     nxt_st = cu_pkg::EXT_WRITE_CACHE_T_OFF;
            cu_pkg::EXT_WRITE_CACHE_T_OFF:
                if (i_int.read_txn_done && !ic.init_read_tx)
                    nxt_st = cu_pkg::EXT_WRITE_CACHE_END;
            cu_pkg::EXT_WRITE_CACHE_END:
                if (cmd.write_cache)
                    nxt_st = cu_pkg::IDLE;
            cu_pkg::EXT_READ_CACHE:      nxt_st = cu_pkg::EXT_READ_CACHE_T_OFF;
            cu_pkg::EXT_READ_CACHE_T_OFF:
                if (i_int.read_txn_done && !ic.init_read_tx)
                    nxt_st = cu_pkg::EXT_READ_CACHE_END;
            cu_pkg::EXT_READ_CACHE_END:
                if (cmd.read_cache)
                    nxt_st = cu_pkg::IDLE;
            cu_pkg::EXT_LAST_WRITE:      nxt_st = cu_pkg::EXT_LAST_WRITE_T_OFF;
            cu_pkg::EXT_LAST_WRITE_T_OFF:
                if (i_int.write_txn_done && !ic.init_write_tx)
                    nxt_st = cu_pkg::EXT_END;
            cu_pkg::EXT_END:
                if (en)
                    nxt_st = cu_pkg::IDLE;
            default: ;
        endcase
        if (fault)
            nxt_st = cu_pkg::ERROR;
        if (i_SYSTEM_rst)
            nxt_st = cu_pkg::RESET;
        // command registers follow the current state.
        if (i_SYSTEM_rst || st == cu_pkg::RESET)
        begin
            cmd = '0;
            ic = '0;
            pd = 1'b0;
            first = 1'b1;
        end
        else
        begin
            case (st)
                cu_pkg::IDLE:
                begin
                    cmd = '0;
                    ic = '0;
                    pd = 1'b0;
                end
                cu_pkg::ERROR:                pd = 1'b0;
                cu_pkg::EXT_WRITE_MEM:        cmd.write_mem = 1'b1;
                cu_pkg::EXT_WRITE_MEM_T_OFF:  cmd.write_mem = 1'b0;
                cu_pkg::EXT_WRITE_MEM_END:    ic.init_write_tx = 1'b1;
                cu_pkg::EXT_WRITE_CACHE:
                begin
                    ic.init_write_tx = 1'b0;
                    ic.init_read_tx = 1'b1;
                    cmd.read_write_id = 1'b1;
                    cmd.write_cache = 1'b0;
                    first = 1'b0;
                end
                cu_pkg::EXT_WRITE_CACHE_T_OFF,
                cu_pkg::EXT_READ_CACHE_T_OFF: ic.init_read_tx = 1'b0;
                cu_pkg::EXT_WRITE_CACHE_END:  cmd.write_cache = 1'b1;
                cu_pkg::EXT_READ_CACHE:       ic.init_read_tx = 1'b1;
                cu_pkg::EXT_READ_CACHE_END:   cmd.read_cache = 1'b1;
                cu_pkg::EXT_LAST_WRITE:       ic.init_write_tx = 1'b1;
                cu_pkg::EXT_LAST_WRITE_T_OFF: ic.init_write_tx = 1'b0;
                cu_pkg::EXT_END:              pd = 1'b1;
                default: ;
            endcase
        end
        if (i_SYSTEM_rst || fin)
        begin
            wr_q = 1'b0;
            rv_q = 1'b0;
            rs_q = 1'b0;
        end
        else
        begin
            wr_q = i_exmu.write_in_cache && !exp_wp;
            rv_q = exp_rp;
            rs_q = i_exmu.read_in_cache && i_ext.read_ready;
        end
        rise = i_pc_ready && !pc_q;
        if (i_SYSTEM_rst || (en && i_ext.done_processing))
            en = 1'b0;
        else if (rise)
            en = 1'b1;
        pc_q = i_SYSTEM_rst ? 1'b0 : i_pc_ready;
        st = nxt_st;
        armed = armed || i_SYSTEM_rst;
    end

    assign o_mismatches = mismatches;
    assign o_seen       = seen;

endmodule

// ==== test/tb_cu_top.sv ====
// control unit testbench
`timescale 1ns/100ps

module tb_cu_top;

    logic                        sys_clk;
    logic                        sys_rst;
    cu_pkg::ext_in_t             ext_in;
    cu_pkg::exmu_in_t            exmu_in;
    cu_pkg::int_stat_t           int_stat;
    cu_pkg::unit_status_t        status_in;
    logic                        pc_ready;
    logic                        frame_done;
    cu_pkg::ext_out_t            ext_out;
    cu_pkg::exmu_cmd_t           cmd_out;
    cu_pkg::exmu_point_t         point_out;
    cu_pkg::int_cmd_t            int_out;
    logic                        ext_ready;
    logic                        proc_done;
    logic [cu_pkg::STATUS_W-1:0] status_out;
    int                          mismatches;
    logic [3:0]                  seen;

    integer seed = 85667;
    int     other_errors = 0;
    int     cycle_count = 0;
    int     timeout_limit;
    int     phase_a_len = 400; // swaps only.
    int     phase_b_len = 300; // swaps and session ends.
    int     phase_w_len = 120; // directed final write-back.
    int     phase_c_len = 40;  // fault.
    int     pc_timer = 8;
    int     rd_hold = 0;
    int     wr_hold = 0;
    logic   pc_level = 1'b0;
    logic   status_locked = 1'b0;

    tb_clock_gen u_clock_gen (.o_clk(sys_clk), .o_rst(sys_rst));

    alfa_cu_top u_alfa_cu_top
    (
        .i_SYSTEM_clk      (sys_clk),
        .i_SYSTEM_rst      (sys_rst),
        .i_ext             (ext_in),
        .i_exmu            (exmu_in),
        .i_int             (int_stat),
        .i_status          (status_in),
        .i_monu_pc_ready   (pc_ready),
        .i_monu_frame_done (frame_done),
        .o_ext             (ext_out),
        .o_cmd             (cmd_out),
        .o_point           (point_out),
        .o_int             (int_out),
        .o_monu_ext_ready  (ext_ready),
        .o_processing_done (proc_done),
        .o_status          (status_out)
    );

    tb_cu_checker u_cu_checker
    (
        .i_SYSTEM_clk    (sys_clk),
        .i_SYSTEM_rst    (sys_rst),
        .i_ext           (ext_in),
        .i_exmu          (exmu_in),
        .i_int           (int_stat),
        .i_status        (status_in),
        .i_pc_ready      (pc_ready),
        .i_dut_ext       (ext_out),
        .i_dut_cmd       (cmd_out),
        .i_dut_point     (point_out),
        .i_dut_int       (int_out),
        .i_dut_ext_ready (ext_ready),
        .i_dut_done      (proc_done),
        .i_dut_status    (status_out),
        .o_mismatches    (mismatches),
        .o_seen          (seen)
    );

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic drive_cycle(input logic allow_done);
        @(posedge sys_clk);
        #2;
        if (pc_timer > 0)
            pc_timer--;
        else
        begin
            pc_level = !pc_level;
            pc_timer = pc_level ? 1 + rand_below(4) : 5 + rand_below(30);
        end
        pc_ready = pc_level;
        ext_in.write_valid = (rand_below(2) == 1);
        ext_in.read_ready = (rand_below(2) == 1);
        ext_in.done_processing = allow_done && (rand_below(30) == 0);
        frame_done = (rand_below(2) == 1);
        if (rand_below(6) == 0)
            exmu_in.write_in_cache = (rand_below(2) == 1);
        if (rand_below(6) == 0)
            exmu_in.read_in_cache = (rand_below(2) == 1);
        // interconnect busy for a random stretch now and then.
        if (rd_hold > 0)
            rd_hold--;
        else if (rand_below(10) == 0)
            rd_hold = 1 + rand_below(12);
        if (wr_hold > 0)
            wr_hold--;
        else if (rand_below(10) == 0)
            wr_hold = 1 + rand_below(12);
        int_stat.read_txn_done = (rd_hold == 0);
        int_stat.write_txn_done = (wr_hold == 0);
        if (!status_locked && rand_below(8) == 0)
        begin
            status_in.memmu = $unsigned($random(seed)) >> 1; // never all ones.
            status_in.exmu = $unsigned($random(seed)) >> 1;
            status_in.monu = $unsigned($random(seed)) >> 1;
        end
    endtask

    task automatic run_phase(input int cycles, input logic allow_done);
        repeat (cycles) drive_cycle(allow_done);
    endtask

    task automatic final_write_back();
        int waited;
        waited = 0;
        while (status_out != 32'(cu_pkg::IDLE) && waited < phase_w_len / 2)
        begin
            drive_cycle(1'b0);
            waited++;
        end
        if (status_out != 32'(cu_pkg::IDLE))
        begin
            other_errors++;
            $display("sequencer never returned to IDLE before the final write-back");
        end
        ext_in.done_processing = 1'b1; // taken on the next edge while in IDLE.
        waited = 0;
        while (proc_done !== 1'b1 && waited < phase_w_len / 2)
        begin
            drive_cycle(1'b0);
            waited++;
        end
        if (proc_done !== 1'b1)
        begin
            other_errors++;
            $display("final write-back never reported processing done");
        end
    endtask

    task automatic inject_fault();
        status_locked = 1'b1;
        case (rand_below(3))
            0:       status_in.memmu = cu_pkg::STATUS_FAULT;
            1:       status_in.exmu = cu_pkg::STATUS_FAULT;
            default: status_in.monu = cu_pkg::STATUS_FAULT;
        endcase
    endtask

    task automatic report_and_finish(input logic timed_out);
        $display("errors: %0d mismatches, %0d other failures", mismatches,
                 other_errors + (timed_out ? 1 : 0));
        if (!timed_out && mismatches == 0 && other_errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    endtask

    initial
    begin
        ext_in = '0;
        exmu_in = '0;
        int_stat = '1;
        status_in = '0;
        pc_ready = 1'b0;
        frame_done = 1'b0;
        while (sys_rst !== 1'b0)
            @(posedge sys_clk);
        run_phase(phase_a_len, 1'b0);
        run_phase(phase_b_len, 1'b1);
        final_write_back();
        inject_fault();
        run_phase(phase_c_len, 1'b0);
        if (seen != 4'b1111)
        begin
            other_errors++;
            $display("not every command sequence was exercised, seen flags %b", seen);
        end
        report_and_finish(1'b0);
    end

    initial
    begin
        timeout_limit = phase_a_len + phase_b_len + phase_w_len + phase_c_len + 200;
        while (cycle_count < timeout_limit)
        begin
            @(posedge sys_clk);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", timeout_limit);
        report_and_finish(1'b1);
    end

endmodule

// ==== verilog/alfa_cu_top.sv ====
// point-cloud control unit
`timescale 1ns/100ps

module alfa_cu_top
(
    input  logic                          i_SYSTEM_clk,
    input  logic                          i_SYSTEM_rst,
    input  cu_pkg::ext_in_t               i_ext,
    input  cu_pkg::exmu_in_t              i_exmu,
    input  cu_pkg::int_stat_t             i_int,
    input  cu_pkg::unit_status_t          i_status,
    input  logic                          i_monu_pc_ready,
    input  logic                          i_monu_frame_done, // reserved for frame tracking.
    output cu_pkg::ext_out_t              o_ext,
    output cu_pkg::exmu_cmd_t             o_cmd,
    output cu_pkg::exmu_point_t           o_point,
    output cu_pkg::int_cmd_t              o_int,
    output logic                          o_monu_ext_ready,
    output logic                          o_processing_done,
    output logic [cu_pkg::STATUS_W-1:0]   o_status
);

    logic               enable;
    logic               finishing;
    logic               write_ready;
    logic               read_valid;
    cu_pkg::cu_state_e  state;

    cu_session_ctrl u_session_ctrl
    (
        .i_SYSTEM_clk      (i_SYSTEM_clk),
        .i_SYSTEM_rst      (i_SYSTEM_rst),
        .i_monu_pc_ready   (i_monu_pc_ready),
        .i_done_processing (i_ext.done_processing),
        .o_enable          (enable)
    );

    cu_point_gate u_point_gate
    (
        .i_SYSTEM_clk  (i_SYSTEM_clk),
        .i_SYSTEM_rst  (i_SYSTEM_rst),
        .i_finishing   (finishing),
        .i_ext         (i_ext),
        .i_exmu        (i_exmu),
        .o_write_ready (write_ready),
        .o_read_valid  (read_valid),
        .o_point       (o_point)
    );

    cu_cache_sequencer u_cache_sequencer
    (
        .i_SYSTEM_clk      (i_SYSTEM_clk),
        .i_SYSTEM_rst      (i_SYSTEM_rst),
        .i_enable          (enable),
        .i_pc_ready        (i_monu_pc_ready),
        .i_done_processing (i_ext.done_processing),
        .i_exmu            (i_exmu),
        .i_int             (i_int),
        .i_status          (i_status),
        .o_cmd             (o_cmd),
        .o_int             (o_int),
        .o_processing_done (o_processing_done),
        .o_finishing       (finishing),
        .o_state           (state)
    );

    assign o_ext.enable      = enable;
    assign o_ext.write_ready = write_ready;
    assign o_ext.read_valid  = read_valid;

    // monitor may hand over a new cloud only between sessions.
    assign o_monu_ext_ready = ~enable;

    assign o_status = {{(cu_pkg::STATUS_W - cu_pkg::STATE_W){1'b0}}, state};

endmodule

// ==== verilog/cu_cache_sequencer.sv ====
// cache swap sequencer
`timescale 1ns/100ps

module cu_cache_sequencer
(
    input  logic                  i_SYSTEM_clk,
    input  logic                  i_SYSTEM_rst,
    input  logic                  i_enable,
    input  logic                  i_pc_ready,
    input  logic                  i_done_processing,
    input  cu_pkg::exmu_in_t      i_exmu,
    input  cu_pkg::int_stat_t     i_int,
    input  cu_pkg::unit_status_t  i_status,
    output cu_pkg::exmu_cmd_t     o_cmd,
    output cu_pkg::int_cmd_t      o_int,
    output logic                  o_processing_done,
    output logic                  o_finishing,
    output cu_pkg::cu_state_e     o_state
);

    cu_pkg::cu_state_e  state_q;
    cu_pkg::exmu_cmd_t  cmd_q;
    cu_pkg::int_cmd_t   int_q;
    logic               processing_done_q;
    logic               first_swap_q;
    logic               fault;
    logic               swap_ok;

    assign fault = (i_status.memmu == cu_pkg::STATUS_FAULT)
                 | (i_status.exmu  == cu_pkg::STATUS_FAULT)
                 | (i_status.monu  == cu_pkg::STATUS_FAULT);

    // both interconnect channels idle.
    assign swap_ok = i_pc_ready & i_int.read_txn_done & i_int.write_txn_done;

    always_ff @(posedge i_SYSTEM_clk)
    begin
        if (i_SYSTEM_rst)
        begin
            state_q <= cu_pkg::RESET;
        end
        else if (fault)
        begin
            state_q <= cu_pkg::ERROR; // sticky until reset.
        end
        else
        begin
            case (state_q)
                cu_pkg::RESET:
                    state_q <= cu_pkg::IDLE;
                cu_pkg::ERROR:
                    state_q <= cu_pkg::ERROR;
                cu_pkg::IDLE:
                begin
                    if (i_done_processing)
                        state_q <= cu_pkg::EXT_LAST_WRITE;
                    else if (swap_ok && !i_exmu.write_in_cache)
                        state_q <= first_swap_q ? cu_pkg::EXT_WRITE_CACHE
                                                : cu_pkg::EXT_WRITE_MEM;
                    else if (swap_ok && !i_exmu.read_in_cache)
                        state_q <= cu_pkg::EXT_READ_CACHE;
                end
                cu_pkg::EXT_WRITE_MEM:
                    state_q <= cu_pkg::EXT_WRITE_MEM_T_OFF;
                cu_pkg::EXT_WRITE_MEM_T_OFF:
                    state_q <= cu_pkg::EXT_WRITE_MEM_END;
                cu_pkg::EXT_WRITE_MEM_END:
                    state_q <= cu_pkg::EXT_WRITE_CACHE;
                cu_pkg::EXT_WRITE_CACHE:
                    state_q <= cu_pkg::EXT_WRITE_CACHE_T_OFF;
                cu_pkg::EXT_WRITE_CACHE_T_OFF:
                    if (i_int.read_txn_done && !int_q.init_read_tx)
                        state_q <= cu_pkg::EXT_WRITE_CACHE_END;
                cu_pkg::EXT_WRITE_CACHE_END:
                    if (cmd_q.write_cache)
                        state_q <= cu_pkg::IDLE;
                cu_pkg::EXT_READ_CACHE:
                    state_q <= cu_pkg::EXT_READ_CACHE_T_OFF;
                cu_pkg::EXT_READ_CACHE_T_OFF:
                    if (i_int.read_txn_done && !int_q.init_read_tx)
                        state_q <= cu_pkg::EXT_READ_CACHE_END;
                cu_pkg::EXT_READ_CACHE_END:
                    if (cmd_q.read_cache)
                        state_q <= cu_pkg::IDLE;
                cu_pkg::EXT_LAST_WRITE:
                    state_q <= cu_pkg::EXT_LAST_WRITE_T_OFF;
                cu_pkg::EXT_LAST_WRITE_T_OFF:
                    if (i_int.write_txn_done && !int_q.init_write_tx)
                        state_q <= cu_pkg::EXT_END;
                cu_pkg::EXT_END:
                    if (i_enable)
                        state_q <= cu_pkg::IDLE; // next session has started.
                default:
                    state_q <= cu_pkg::IDLE;
            endcase
        end
    end

    // commands follow the state by one cycle.
    always_ff @(posedge i_SYSTEM_clk)
    begin
        if (i_SYSTEM_rst || state_q == cu_pkg::RESET)
        begin
            cmd_q             <= '0;
            int_q             <= '0;
            processing_done_q <= 1'b0;
            first_swap_q      <= 1'b1;
        end
        else
        begin
            case (state_q)
                cu_pkg::IDLE:
                begin
                    cmd_q             <= '0;
                    int_q             <= '0;
                    processing_done_q <= 1'b0;
                end
                cu_pkg::ERROR:
                    processing_done_q <= 1'b0;
                cu_pkg::EXT_WRITE_MEM:
                    cmd_q.write_mem <= 1'b1;
                cu_pkg::EXT_WRITE_MEM_T_OFF:
                    cmd_q.write_mem <= 1'b0;
                cu_pkg::EXT_WRITE_MEM_END:
                    int_q.init_write_tx <= 1'b1;
                cu_pkg::EXT_WRITE_CACHE:
                begin
                    int_q.init_write_tx <= 1'b0;
                    int_q.init_read_tx  <= 1'b1;
                    cmd_q.read_write_id <= 1'b1;
                    cmd_q.write_cache   <= 1'b0;
                    first_swap_q        <= 1'b0;
                end
                cu_pkg::EXT_WRITE_CACHE_T_OFF,
                cu_pkg::EXT_READ_CACHE_T_OFF:
                    int_q.init_read_tx <= 1'b0;
                cu_pkg::EXT_WRITE_CACHE_END:
                    cmd_q.write_cache <= 1'b1;
                cu_pkg::EXT_READ_CACHE:
                    int_q.init_read_tx <= 1'b1;
                cu_pkg::EXT_READ_CACHE_END:
                    cmd_q.read_cache <= 1'b1;
                cu_pkg::EXT_LAST_WRITE:
                    int_q.init_write_tx <= 1'b1;
                cu_pkg::EXT_LAST_WRITE_T_OFF:
                    int_q.init_write_tx <= 1'b0;
                cu_pkg::EXT_END:
                    processing_done_q <= 1'b1;
                default:
                begin
                    cmd_q             <= '0;
                    int_q             <= '0;
                    processing_done_q <= 1'b0;
                    first_swap_q      <= 1'b1;
                end
            endcase
        end
    end

    assign o_finishing = (state_q == cu_pkg::EXT_LAST_WRITE)
                       | (state_q == cu_pkg::EXT_LAST_WRITE_T_OFF)
                       | (state_q == cu_pkg::EXT_END);

    assign o_cmd             = cmd_q;
    assign o_int             = int_q;
    assign o_processing_done = processing_done_q;
    assign o_state           = state_q;

endmodule

// ==== verilog/cu_pkg.sv ====
// control unit definitions
package cu_pkg;

    localparam int STATUS_W = 32;
    localparam logic [STATUS_W-1:0] STATUS_FAULT = {STATUS_W{1'b1}}; // unit fault marker.
    localparam int STATE_W = 5;

    // codes 2, 3 and 18 to 30 are unused.
    typedef enum logic [STATE_W-1:0] {
        RESET                 = 5'd0,
        IDLE                  = 5'd1,
        EXT_READ_POINT        = 5'd4,
        EXT_READ_CACHE        = 5'd5,
        EXT_READ_CACHE_T_OFF  = 5'd6,
        EXT_READ_CACHE_END    = 5'd7,
        EXT_WRITE_POINT       = 5'd8,
        EXT_WRITE_CACHE       = 5'd9,
        EXT_WRITE_CACHE_T_OFF = 5'd10,
        EXT_WRITE_CACHE_END   = 5'd11,
        EXT_WRITE_MEM         = 5'd12,
        EXT_WRITE_MEM_T_OFF   = 5'd13,
        EXT_WRITE_MEM_END     = 5'd14,
        EXT_LAST_WRITE        = 5'd15,
        EXT_LAST_WRITE_T_OFF  = 5'd16,
        EXT_END               = 5'd17,
        ERROR                 = 5'd31
    } cu_state_e;

    typedef struct packed {
        logic write_valid;
        logic read_ready;
        logic done_processing;
    } ext_in_t;

    typedef struct packed {
        logic enable;
        logic write_ready;
        logic read_valid;
    } ext_out_t;

    typedef struct packed {
        logic read_in_cache;
        logic write_in_cache;
    } exmu_in_t;

    typedef struct packed {
        logic read_cache;
        logic write_cache;
        logic read_write_id; // selects the write cache on a read transaction.
        logic write_mem;
    } exmu_cmd_t;

    typedef struct packed {
        logic read_point;
        logic write_point;
    } exmu_point_t;

    typedef struct packed {
        logic init_write_tx;
        logic init_read_tx;
    } int_cmd_t;

    typedef struct packed {
        logic write_txn_done;
        logic read_txn_done;
    } int_stat_t;

    typedef struct packed {
        logic [STATUS_W-1:0] memmu;
        logic [STATUS_W-1:0] exmu;
        logic [STATUS_W-1:0] monu;
    } unit_status_t;

endpackage

// ==== verilog/cu_point_gate.sv ====
// point transfer gate
`timescale 1ns/100ps

module cu_point_gate
(
    input  logic                  i_SYSTEM_clk,
    input  logic                  i_SYSTEM_rst,
    input  logic                  i_finishing,
    input  cu_pkg::ext_in_t       i_ext,
    input  cu_pkg::exmu_in_t      i_exmu,
    output logic                  o_write_ready,
    output logic                  o_read_valid,
    output cu_pkg::exmu_point_t   o_point
);

    logic write_ready_q;
    logic read_valid_q;
    logic read_seen_q;
    logic read_req;
    logic write_point;
    logic read_point;

    assign read_req = i_exmu.read_in_cache & i_ext.read_ready;

    // one write per cycle while the cache has room and the engine offers data.
    assign write_point = ~i_finishing & i_exmu.write_in_cache & write_ready_q
                       & i_ext.write_valid;

    // only the first cycle of a read request passes.
    assign read_point = ~i_finishing & read_req & ~read_seen_q;

    always_ff @(posedge i_SYSTEM_clk)
    begin
        if (i_SYSTEM_rst || i_finishing)
        begin
            write_ready_q <= 1'b0;
            read_valid_q  <= 1'b0;
            read_seen_q   <= 1'b0;
        end
        else
        begin
            write_ready_q <= i_exmu.write_in_cache & ~write_point; // drop after each write.
            read_valid_q  <= read_point;
            read_seen_q   <= read_req;
        end
    end

    assign o_write_ready       = write_ready_q;
    assign o_read_valid        = read_valid_q;
    assign o_point.read_point  = read_point;
    assign o_point.write_point = write_point;

endmodule

// ==== verilog/cu_session_ctrl.sv ====
// processing session enable
`timescale 1ns/100ps

module cu_session_ctrl
(
    input  logic i_SYSTEM_clk,
    input  logic i_SYSTEM_rst,
    input  logic i_monu_pc_ready,
    input  logic i_done_processing,
    output logic o_enable
);

    logic pc_ready_q;
    logic enable_q;
    logic pc_ready_rise;
    logic session_done;

    assign pc_ready_rise = i_monu_pc_ready & ~pc_ready_q;
    assign session_done  = enable_q & i_done_processing;

    // previous monitor level for edge detection.
    always_ff @(posedge i_SYSTEM_clk)
    begin
        if (i_SYSTEM_rst)
        begin
            pc_ready_q <= 1'b0;
        end
        else
        begin
            pc_ready_q <= i_monu_pc_ready;
        end
    end

    // engine done wins over a new point cloud in the same cycle.
    always_ff @(posedge i_SYSTEM_clk)
    begin
        if (i_SYSTEM_rst)
        begin
            enable_q <= 1'b0;
        end
        else if (session_done)
        begin
            enable_q <= 1'b0;
        end
        else if (pc_ready_rise)
        begin
            enable_q <= 1'b1;
        end
    end

    assign o_enable = enable_q;

endmodule
